/* Bender.yml */
package:
  name: eth_rx

sources:
  - include_dirs:
      - common
    files:
      - common/eth_frame_pkg.sv
      - common/eth_rx_ctrl_pkg.sv
      - common/rx_byte_if.sv
      - source/mii_nibble_assembler.sv
      - rx_frame/rx_byte_counter.sv
      - rx_frame/rx_header_capture.sv
      - rx_frame/rx_frame_fsm.sv
      - source/eth_crc32_check.sv
      - source/eth_rx_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_eth_rx_top.sv

/* common/eth_consts.svh */
`ifndef ETH_CONSTS_SVH
`define ETH_CONSTS_SVH

// field lengths in bytes
`define ETH_HDR_ADDR_LEN 6
`define ETH_PAYLOAD_LEN 46
`define ETH_FCS_LEN 4

// widths
`define ETH_BYTE_W 8
`define ETH_MAC_ADDR_W 48
`define ETH_BUF_ADDR_W 6
`define ETH_CNT_W 6
`define ETH_CRC_W 32

// line codes, as bytes after nibble pairing
`define ETH_PREAMBLE_NIB 4'h5
`define ETH_SFD 8'hD5

// 0x04C11DB7 bit-reversed, for the LSB-first shift
`define ETH_CRC_POLY_REFL 32'hEDB88320

// what is left after a good frame including its FCS
`define ETH_CRC_RESIDUE 32'hC704DD7B

`endif

/* common/eth_frame_pkg.sv */
`include "eth_consts.svh"

package eth_frame_pkg;

   // one received octet
   typedef logic [`ETH_BYTE_W-1:0] eth_byte_t;

   typedef logic [`ETH_MAC_ADDR_W-1:0] mac_addr_t;

   // payload buffer word address
   typedef logic [`ETH_BUF_ADDR_W-1:0] buf_addr_t;

   typedef logic [`ETH_CRC_W-1:0] crc_t;

   // position inside the current field
   typedef logic [`ETH_CNT_W-1:0] byte_cnt_t;

endpackage

/* common/eth_rx_ctrl_pkg.sv */
package eth_rx_ctrl_pkg;

   // receiver states, in frame order
   typedef enum logic [2:0] {
      st_idle,
      st_preamble,
      st_dst,
      st_src,
      st_payload,
      st_fcs,
      st_drop
   } rx_state_t;

   // which address register takes the byte stream
   typedef enum logic [1:0] {
      fld_none,
      fld_dst,
      fld_src
   } hdr_field_t;

endpackage

/* common/rx_byte_if.sv */
interface rx_byte_if;
   import eth_frame_pkg::*;

   // new byte, one cycle
   logic      byte_stb;
   // valid only with byte_stb
   eth_byte_t byte_data;
   // SFD found while hunting
   logic      sfd_stb;
   // cycle after RX_DV fell
   logic      dv_end;

   modport source (
      output byte_stb,
      output byte_data,
      output sfd_stb,
      output dv_end
   );

   modport sink (
      input byte_stb,
      input byte_data,
      input sfd_stb,
      input dv_end
   );

endinterface

/* eth_rx_top.f */
+incdir+common
common/eth_frame_pkg.sv
common/eth_rx_ctrl_pkg.sv
common/rx_byte_if.sv
source/mii_nibble_assembler.sv
rx_frame/rx_byte_counter.sv
rx_frame/rx_header_capture.sv
rx_frame/rx_frame_fsm.sv
source/eth_crc32_check.sv
source/eth_rx_top.sv
sim/tb_eth_rx_top.sv

/* rx_frame/rx_byte_counter.sv */
`include "eth_consts.svh"

module rx_byte_counter (
   input  logic                     RX_CLK,
   input  logic                     rx_rst,
   input  logic                     clr,
   input  logic                     inc,
   output eth_frame_pkg::byte_cnt_t cnt
);
   import eth_frame_pkg::*;

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         cnt <= '0;
      end else if (clr) begin
         // field boundary wins over a byte
         cnt <= '0;
      end else if (inc) begin
         cnt <= cnt + byte_cnt_t'(1);
      end
   end

   // the longest field is the payload, its last byte clears
   a_no_overrun: assert property (
      @(posedge RX_CLK) disable iff (rx_rst)
      inc && !clr |-> cnt < byte_cnt_t'(`ETH_PAYLOAD_LEN - 1)
   );

endmodule

/* rx_frame/rx_frame_fsm.sv */
`include "eth_consts.svh"

module rx_frame_fsm (
   input  logic                       RX_CLK,
   input  logic                       rx_rst,
   rx_byte_if.sink                    rx_bus,
   input  eth_frame_pkg::byte_cnt_t   cnt,
   input  logic                       dst_match,
   input  logic                       crc_ok,
   output logic                       cnt_clr,
   output logic                       cnt_inc,
   output eth_rx_ctrl_pkg::hdr_field_t field,
   output logic                       crc_init,
   output logic                       buf_wr,
   output logic                       frame_done,
   output logic                       frame_ok
);
   import eth_frame_pkg::*;
   import eth_rx_ctrl_pkg::*;

   rx_state_t state;
   rx_state_t state_nxt;
   byte_cnt_t last_cnt;
   logic      field_last;
   // check pending one cycle after the last DST or FCS byte
   logic      chk_q;
   logic      chk_nxt;

   always_comb begin
      case (state)
         st_dst, st_src: last_cnt = byte_cnt_t'(`ETH_HDR_ADDR_LEN - 1);
         st_payload:     last_cnt = byte_cnt_t'(`ETH_PAYLOAD_LEN - 1);
         default:        last_cnt = byte_cnt_t'(`ETH_FCS_LEN - 1);
      endcase
   end

   assign field_last = rx_bus.byte_stb && cnt == last_cnt;

   always_comb begin
      state_nxt = state;
      chk_nxt   = 1'b0;
      cnt_clr   = 1'b0;
      cnt_inc   = 1'b0;
      crc_init  = 1'b0;
      buf_wr    = 1'b0;
      field     = fld_none;
      case (state)
         st_idle, st_preamble: begin
            cnt_clr = 1'b1;
            if (rx_bus.sfd_stb) begin
               crc_init  = 1'b1;
               state_nxt = st_dst;
            end else begin
               state_nxt = st_preamble;
            end
         end
         st_dst: begin
            field   = fld_dst;
            cnt_inc = rx_bus.byte_stb;
            if (field_last) begin
               cnt_clr   = 1'b1;
               chk_nxt   = 1'b1;
               state_nxt = st_src;
            end
         end
         st_src: begin
            field   = fld_src;
            cnt_inc = rx_bus.byte_stb;
            // dst register holds all six bytes by now
            if (chk_q && !dst_match) begin
               state_nxt = st_drop;
            end else if (field_last) begin
               cnt_clr   = 1'b1;
               state_nxt = st_payload;
            end
         end
         st_payload: begin
            cnt_inc = rx_bus.byte_stb;
            buf_wr  = rx_bus.byte_stb;
            if (field_last) begin
               cnt_clr   = 1'b1;
               state_nxt = st_fcs;
            end
         end
         st_fcs: begin
            cnt_inc = rx_bus.byte_stb;
            if (field_last) begin
               cnt_clr   = 1'b1;
               chk_nxt   = 1'b1;
               state_nxt = st_idle;
            end
         end
         st_drop: begin
            // ignore the rest of the frame
            state_nxt = st_drop;
         end
         default: state_nxt = st_idle;
      endcase

      // frame cut short or finished dropping
      if (rx_bus.dv_end && state inside {st_dst, st_src, st_payload, st_fcs, st_drop}) begin
         state_nxt = st_idle;
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state      <= st_idle;
         chk_q      <= 1'b0;
         frame_done <= 1'b0;
         frame_ok   <= 1'b0;
      end else begin
         state      <= state_nxt;
         chk_q      <= chk_nxt;
         frame_done <= chk_q && state == st_idle;
         if (chk_q && state == st_idle) begin
            frame_ok <= crc_ok;
         end
      end
   end

   // writes stay inside the payload window of the buffer
   a_wr_in_payload: assert property (
      @(posedge RX_CLK) disable iff (rx_rst)
      buf_wr |-> state == st_payload && cnt < byte_cnt_t'(`ETH_PAYLOAD_LEN)
   );

endmodule

/* rx_frame/rx_header_capture.sv */
module rx_header_capture (
   input  logic                        RX_CLK,
   input  logic                        rx_rst,
   rx_byte_if.sink                     rx_bus,
   input  eth_rx_ctrl_pkg::hdr_field_t field,
   input  eth_frame_pkg::mac_addr_t    mac_addr,
   output logic                        dst_match,
   output eth_frame_pkg::mac_addr_t    src_mac_addr
);
   import eth_frame_pkg::*;
   import eth_rx_ctrl_pkg::*;

   // top bit kept on each shift
   localparam int keep_hi = $bits(mac_addr_t) - $bits(eth_byte_t) - 1;

   mac_addr_t dst_q;

   // first byte on the wire ends up most significant
   always_ff @(posedge RX_CLK) begin
      if (rx_bus.byte_stb && field == fld_dst) begin
         dst_q <= {dst_q[keep_hi:0], rx_bus.byte_data};
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         src_mac_addr <= '0;
      end else if (rx_bus.byte_stb && field == fld_src) begin
         src_mac_addr <= {src_mac_addr[keep_hi:0], rx_bus.byte_data};
      end
   end

   // own address or broadcast
   assign dst_match = (dst_q == mac_addr) || (&dst_q);

endmodule

/* sim/tb_eth_rx_top.sv */
`include "eth_consts.svh"

module tb_eth_rx_top;
   timeunit 1ns;
   timeprecision 100ps;
   import eth_frame_pkg::*;

   localparam int hdr_len = 2 * `ETH_HDR_ADDR_LEN;
   localparam int body_len = hdr_len + `ETH_PAYLOAD_LEN;
   // 12 byte inter-frame gap, two nibble cycles per byte
   localparam int gap_cycles = 24;
   // ten frames of about 140 cycles plus gaps come to under 2000 cycles
   localparam int max_cycles = 3000;
   localparam mac_addr_t own_mac = 48'h02005E102030;
   localparam mac_addr_t other_mac = 48'h02005E999999;

   logic       RX_CLK;
   logic       rx_rst;
   logic       RX_DV;
   logic [3:0] RX_DATA;
   mac_addr_t  mac_addr;
   buf_addr_t  buf_addr;
   eth_byte_t  buf_data;
   logic       buf_wr;
   mac_addr_t  src_mac_addr;
   logic       frame_done;
   logic       frame_ok;

   eth_byte_t payload [`ETH_PAYLOAD_LEN];
   // dst, src and payload as sent, the FCS covers these
   eth_byte_t body [body_len];
   buf_addr_t wr_addr_q [$];
   eth_byte_t wr_data_q [$];
   int        done_cnt;
   logic      done_ok;
   mac_addr_t done_src;
   int        cycles;
   int        checks;
   int        errors;
   int        tests;
   int        seed;

   eth_rx_top u_eth_rx_top (
      .RX_CLK       (RX_CLK),
      .rx_rst       (rx_rst),
      .RX_DV        (RX_DV),
      .RX_DATA      (RX_DATA),
      .mac_addr     (mac_addr),
      .buf_addr     (buf_addr),
      .buf_data     (buf_data),
      .buf_wr       (buf_wr),
      .src_mac_addr (src_mac_addr),
      .frame_done   (frame_done),
      .frame_ok     (frame_ok)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #4 RX_CLK = ~RX_CLK;
   end

   always @(posedge RX_CLK) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout: run stopped after %0d cycles without finishing", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   // outputs all come from registers, stable at the falling edge
   always @(negedge RX_CLK) begin
      if (!rx_rst && buf_wr) begin
         wr_addr_q.push_back(buf_addr);
         wr_data_q.push_back(buf_data);
      end
      if (!rx_rst && frame_done) begin
         done_cnt = done_cnt + 1;
         done_ok  = frame_ok;
         done_src = src_mac_addr;
      end
   end

   // CRC-32 MSB first over the bits in wire order
   function automatic crc_t fcs_of_body();
      crc_t c;
      crc_t rev;
      logic fb;
      c = '1;
      foreach (body[i]) begin
         for (int b = 0; b < 8; b++) begin
            fb = c[31] ^ body[i][b];
            c  = {c[30:0], 1'b0};
            if (fb) begin
               c = c ^ 32'h04C11DB7;
            end
         end
      end
      for (int i = 0; i < 32; i++) begin
         rev[i] = c[31 - i];
      end
      return ~rev;
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic send_byte(input eth_byte_t b);
      @(negedge RX_CLK);
      RX_DV   = 1'b1;
      RX_DATA = b[3:0];
      @(negedge RX_CLK);
      RX_DATA = b[7:4];
   endtask

   // cut >= 0 ends RX_DV after that many payload bytes
   task automatic send_frame(input mac_addr_t dst, input mac_addr_t src,
                             input bit corrupt, input int cut);
      crc_t fcs;
      int   n;
      for (int i = 0; i < `ETH_HDR_ADDR_LEN; i++) begin
         body[i] = dst[47 - 8 * i -: 8];
         body[`ETH_HDR_ADDR_LEN + i] = src[47 - 8 * i -: 8];
      end
      for (int i = 0; i < `ETH_PAYLOAD_LEN; i++) begin
         body[hdr_len + i] = payload[i];
      end
      fcs = fcs_of_body();
      if (corrupt) begin
         body[hdr_len + 20] = body[hdr_len + 20] ^ 8'h40;
      end
      n = (cut >= 0) ? hdr_len + cut : body_len;
      repeat (7) send_byte(8'h55);
      send_byte(`ETH_SFD);
      for (int i = 0; i < n; i++) begin
         send_byte(body[i]);
      end
      if (cut < 0) begin
         for (int i = 0; i < `ETH_FCS_LEN; i++) begin
            send_byte(fcs[8 * i +: 8]);
         end
      end
      @(negedge RX_CLK);
      RX_DV   = 1'b0;
      RX_DATA = '0;
   endtask

   task automatic clear_monitor();
      @(posedge RX_CLK);
      wr_addr_q.delete();
      wr_data_q.delete();
      done_cnt = 0;
   endtask

   task automatic fill_payload();
      foreach (payload[i]) begin
         payload[i] = eth_byte_t'($urandom);
      end
   endtask

   // waits out the gap, frame_done is expected inside it
   task automatic check_frame(input mac_addr_t src, input bit exp_ok);
      int waited;
      waited = 0;
      while (done_cnt == 0 && waited < gap_cycles) begin
         @(posedge RX_CLK);
         waited++;
      end
      check_value("frame_done count", done_cnt, 1);
      check_value("frame_ok", done_ok, exp_ok);
      check_value("src_mac_addr", done_src, src);
      check_value("payload write count", wr_addr_q.size(), `ETH_PAYLOAD_LEN);
      foreach (wr_addr_q[i]) begin
         check_value("buf_addr", wr_addr_q[i], i);
         check_value("buf_data", wr_data_q[i], body[hdr_len + i]);
      end
      repeat (gap_cycles - waited) @(posedge RX_CLK);
      clear_monitor();
   endtask

   task automatic report_test(input string name, input int err_start);
      tests++;
      if (errors == err_start) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_start);
      end
   endtask

   task automatic run_good(input mac_addr_t dst, input mac_addr_t src, input bit corrupt);
      fill_payload();
      send_frame(dst, src, corrupt, -1);
      check_frame(src, !corrupt);
   endtask

   task automatic test_unicast();
      int e0;
      e0 = errors;
      run_good(own_mac, 48'h001B213C4D5E, 1'b0);
      report_test("unicast", e0);
   endtask

   task automatic test_broadcast();
      int e0;
      e0 = errors;
      run_good('1, 48'h00A0C9112233, 1'b0);
      report_test("broadcast", e0);
   endtask

   task automatic test_other_dst();
      int e0;
      e0 = errors;
      fill_payload();
      send_frame(other_mac, 48'h00A0C9445566, 1'b0, -1);
      repeat (gap_cycles) @(posedge RX_CLK);
      check_value("writes of foreign frame", wr_addr_q.size(), 0);
      check_value("frame_done of foreign frame", done_cnt, 0);
      clear_monitor();
      run_good(own_mac, 48'h00A0C9778899, 1'b0);
      report_test("other destination", e0);
   endtask

   task automatic test_bad_fcs();
      int e0;
      e0 = errors;
      run_good(own_mac, 48'h0010A4010203, 1'b1);
      report_test("corrupted payload", e0);
   endtask

   task automatic test_cut_frame();
      int e0;
      e0 = errors;
      fill_payload();
      send_frame(own_mac, 48'h0010A4040506, 1'b0, 20);
      repeat (gap_cycles) @(posedge RX_CLK);
      check_value("frame_done of cut frame", done_cnt, 0);
      clear_monitor();
      run_good(own_mac, 48'h0010A4070809, 1'b0);
      report_test("RX_DV dropped", e0);
   endtask

   task automatic test_back_to_back();
      int        e0;
      mac_addr_t src;
      e0 = errors;
      repeat (3) begin
         src = {16'($urandom), 32'($urandom)};
         run_good(own_mac, src, 1'b0);
      end
      report_test("back to back", e0);
   endtask

   initial begin
      seed = 54223;
      void'($urandom(seed));
      rx_rst   = 1'b1;
      RX_DV    = 1'b0;
      RX_DATA  = '0;
      mac_addr = own_mac;
      cycles   = 0;
      checks   = 0;
      errors   = 0;
      tests    = 0;
      done_cnt = 0;
      repeat (10) @(posedge RX_CLK);
      @(negedge RX_CLK);
      rx_rst = 1'b0;
      clear_monitor();
      test_unicast();
      test_broadcast();
      test_other_dst();
      test_bad_fcs();
      test_cut_frame();
      test_back_to_back();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* source/eth_crc32_check.sv */
`include "eth_consts.svh"

module eth_crc32_check (
   input  logic    RX_CLK,
   input  logic    rx_rst,
   rx_byte_if.sink rx_bus,
   input  logic    init,
   output logic    crc_ok
);
   import eth_frame_pkg::*;

   crc_t crc_q;
   crc_t crc_nxt;
   crc_t crc_rev;

   // one byte, LSB first, eight shift steps
   always_comb begin
      crc_nxt = crc_q ^ crc_t'(rx_bus.byte_data);
      for (int i = 0; i < $bits(eth_byte_t); i++) begin
         if (crc_nxt[0]) begin
            crc_nxt = (crc_nxt >> 1) ^ `ETH_CRC_POLY_REFL;
         end else begin
            crc_nxt = crc_nxt >> 1;
         end
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc_q <= '1;
      end else if (init) begin
         crc_q <= '1;
      end else if (rx_bus.byte_stb) begin
         crc_q <= crc_nxt;
      end
   end

   // register runs reflected, the residue is given MSB first
   always_comb begin
      for (int i = 0; i < $bits(crc_t); i++) begin
         crc_rev[i] = crc_q[$bits(crc_t) - 1 - i];
      end
   end

   assign crc_ok = crc_rev == `ETH_CRC_RESIDUE;

endmodule

/* source/eth_rx_top.sv */
module eth_rx_top (
   input  logic                     RX_CLK,
   input  logic                     rx_rst,
   input  logic                     RX_DV,
   input  logic [3:0]               RX_DATA,
   input  eth_frame_pkg::mac_addr_t mac_addr,
   output eth_frame_pkg::buf_addr_t buf_addr,
   output eth_frame_pkg::eth_byte_t buf_data,
   output logic                     buf_wr,
   output eth_frame_pkg::mac_addr_t src_mac_addr,
   output logic                     frame_done,
   output logic                     frame_ok
);
   import eth_frame_pkg::*;
   import eth_rx_ctrl_pkg::*;

   byte_cnt_t  cnt;
   logic       cnt_clr;
   logic       cnt_inc;
   hdr_field_t field;
   logic       dst_match;
   logic       crc_init;
   logic       crc_ok;

   rx_byte_if rx_bus ();

   mii_nibble_assembler u_nibble_asm (
      .RX_CLK  (RX_CLK),
      .rx_rst  (rx_rst),
      .RX_DV   (RX_DV),
      .RX_DATA (RX_DATA),
      .rx_bus  (rx_bus.source)
   );

   rx_frame_fsm u_frame_fsm (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .rx_bus     (rx_bus.sink),
      .cnt        (cnt),
      .dst_match  (dst_match),
      .crc_ok     (crc_ok),
      .cnt_clr    (cnt_clr),
      .cnt_inc    (cnt_inc),
      .field      (field),
      .crc_init   (crc_init),
      .buf_wr     (buf_wr),
      .frame_done (frame_done),
      .frame_ok   (frame_ok)
   );

   rx_byte_counter u_byte_cnt (
      .RX_CLK (RX_CLK),
      .rx_rst (rx_rst),
      .clr    (cnt_clr),
      .inc    (cnt_inc),
      .cnt    (cnt)
   );

   rx_header_capture u_hdr_cap (
      .RX_CLK       (RX_CLK),
      .rx_rst       (rx_rst),
      .rx_bus       (rx_bus.sink),
      .field        (field),
      .mac_addr     (mac_addr),
      .dst_match    (dst_match),
      .src_mac_addr (src_mac_addr)
   );

   eth_crc32_check u_crc_chk (
      .RX_CLK (RX_CLK),
      .rx_rst (rx_rst),
      .rx_bus (rx_bus.sink),
      .init   (crc_init),
      .crc_ok (crc_ok)
   );

   // payload byte k lands at address k
   assign buf_addr = buf_addr_t'(cnt);
   assign buf_data = rx_bus.byte_data;

endmodule

/* source/mii_nibble_assembler.sv */
`include "eth_consts.svh"

module mii_nibble_assembler (
   input  logic       RX_CLK,
   input  logic       rx_rst,
   input  logic       RX_DV,
   input  logic [3:0] RX_DATA,
   rx_byte_if.source  rx_bus
);
   import eth_frame_pkg::*;

   logic [3:0] nib_q;
   logic [3:0] nib_qq;
   logic       locked;
   logic       phase;
   logic       dv_q;
   logic       sfd_hit;
   logic       byte_done;
   eth_byte_t  pair;

   // current nibble is the high half, the one before it the low half
   assign pair = {RX_DATA, nib_q};

   // SFD low nibble must follow a preamble nibble
   assign sfd_hit = RX_DV && !locked && pair == `ETH_SFD && nib_qq == `ETH_PREAMBLE_NIB;

   assign byte_done = RX_DV && locked && phase;

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         nib_q           <= '0;
         nib_qq          <= '0;
         locked          <= 1'b0;
         phase           <= 1'b0;
         dv_q            <= 1'b0;
         rx_bus.byte_stb <= 1'b0;
         rx_bus.sfd_stb  <= 1'b0;
         rx_bus.dv_end   <= 1'b0;
      end else begin
         dv_q            <= RX_DV;
         rx_bus.dv_end   <= dv_q && !RX_DV;
         rx_bus.sfd_stb  <= sfd_hit;
         rx_bus.byte_stb <= byte_done;
         if (!RX_DV) begin
            // line idle, drop alignment and history
            nib_q  <= '0;
            nib_qq <= '0;
            locked <= 1'b0;
            phase  <= 1'b0;
         end else begin
            nib_q  <= RX_DATA;
            nib_qq <= nib_q;
            if (sfd_hit) begin
               locked <= 1'b1;
               phase  <= 1'b0;
            end else if (locked) begin
               phase <= !phase;
            end
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (byte_done) begin
         rx_bus.byte_data <= pair;
      end
   end

   // two nibbles per byte
   a_stb_spacing: assert property (
      @(posedge RX_CLK) disable iff (rx_rst) rx_bus.byte_stb |=> !rx_bus.byte_stb
   );

endmodule
